/* src/ccipAfu_settings.svh */
// Width, depth and identity macros for the copy accelerator shell
`ifndef CCIPAFU_SETTINGS_SVH
`define CCIPAFU_SETTINGS_SVH

// Data line width and host line address width
`define LINE_BITS 64
`define ADDR_BITS 32

// Read request tag carried in mdata
`define MDATA_BITS 8

// MMIO byte address and transaction ID widths
`define MMIO_ADDR_BITS 16
`define MMIO_TID_BITS 9

// Reads in flight, one reorder slot each, kept a power of two
`define REORDER_DEPTH 8

// Feature ID read back at MMIO offset 0x8
`define AFU_ID 64'h5a3c_19e7_c0de_0b41

`endif

/* src/ccipAfuPkg.sv */
// Request, response and job types of the copy accelerator
// CSR byte offsets and the device feature header value
`include "ccipAfu_settings.svh"

package ccipAfuPkg;

  // Reorder slot index, carried in the low bits of the read mdata
  localparam int TAG_BITS = $clog2(`REORDER_DEPTH);

  typedef logic [`MMIO_ADDR_BITS-1:0] tMmioAddr;

  // MMIO request as delivered to the CSR block
  typedef struct packed {
    logic                      wrValid;
    logic                      rdValid;
    tMmioAddr                  addr;
    logic [`MMIO_TID_BITS-1:0] tid;
    logic [`LINE_BITS-1:0]     data;
  } tMmioReq;

  // MMIO read response, returned with the request's transaction ID
  typedef struct packed {
    logic                      valid;
    logic [`MMIO_TID_BITS-1:0] tid;
    logic [`LINE_BITS-1:0]     data;
  } tMmioRsp;

  // Host responses: read data tagged by mdata and write acknowledges
  typedef struct packed {
    logic                   rdValid;
    logic [`MDATA_BITS-1:0] mdata;
    logic [`LINE_BITS-1:0]  data;
    logic                   wrAck;
  } tHostRsp;

  // One copy job as programmed over MMIO
  typedef struct packed {
    logic [`ADDR_BITS-1:0] src;
    logic [`ADDR_BITS-1:0] dst;
    logic [15:0]           lines;
    logic [`ADDR_BITS-1:0] dsm;
  } tJob;

  // AFU feature type in bits 63:60, end of the feature list in bit 40
  localparam logic [63:0] DFH_VALUE = 64'h1000_0100_0000_0000;

  // CSR byte offsets
  localparam tMmioAddr CSR_DFH    = 'h00;
  localparam tMmioAddr CSR_ID     = 'h08;
  localparam tMmioAddr CSR_SRC    = 'h10;
  localparam tMmioAddr CSR_DST    = 'h18;
  localparam tMmioAddr CSR_LINES  = 'h20;
  localparam tMmioAddr CSR_DSM    = 'h28;
  localparam tMmioAddr CSR_CTRL   = 'h30;
  localparam tMmioAddr CSR_STATUS = 'h38;

endpackage

/* src/writeReqIf.sv */
// Write request channel between one requester and the write arbiter
`include "ccipAfu_settings.svh"

interface writeReqIf;

  // The requester keeps valid, addr and data steady until grant is high
  logic                  valid;
  logic [`ADDR_BITS-1:0] addr;
  logic [`LINE_BITS-1:0] data;

  // Grant is combinational and means the write goes out this cycle
  logic                  grant;

  modport requester (output valid, output addr, output data, input grant);
  modport arbiter (input valid, input addr, input data, output grant);

endinterface

/* src/hostRxSplit.sv */
// Registered host boundary: Rx capture split into MMIO and host paths
// Registered Tx outputs for reads, writes and MMIO responses
`include "ccipAfu_settings.svh"

module hostRxSplit
  import ccipAfuPkg::*;
(
  input  logic                       pClk,
  input  logic                       rst,
  // Shared Rx bus from the host
  input  logic                       c0RspValid,
  input  logic [`MDATA_BITS-1:0]     c0RspMdata,
  input  logic [`LINE_BITS-1:0]      c0RspData,
  input  logic                       c0MmioWrValid,
  input  logic                       c0MmioRdValid,
  input  logic [`MMIO_ADDR_BITS-1:0] c0MmioAddr,
  input  logic [`MMIO_TID_BITS-1:0]  c0MmioTid,
  input  logic [`LINE_BITS-1:0]      c0MmioData,
  input  logic                       c1RspValid,
  input  logic                       c0TxAlmFull,
  input  logic                       c1TxAlmFull,
  // Tx bus to the host
  output logic                       c0ReqValid,
  output logic [`ADDR_BITS-1:0]      c0ReqAddr,
  output logic [`MDATA_BITS-1:0]     c0ReqMdata,
  output logic                       c1ReqValid,
  output logic [`ADDR_BITS-1:0]      c1ReqAddr,
  output logic [`LINE_BITS-1:0]      c1ReqData,
  output logic                       c2MmioRspValid,
  output logic [`MMIO_TID_BITS-1:0]  c2MmioRspTid,
  output logic [`LINE_BITS-1:0]      c2MmioRspData,
  // Internal side
  output tMmioReq                    mmioReq,
  input  tMmioRsp                    mmioRsp,
  output tHostRsp                    hostRsp,
  output logic                       c0AlmFull,
  output logic                       c1AlmFull,
  input  logic                       rdReqValid,
  input  logic [`ADDR_BITS-1:0]      rdReqAddr,
  input  logic [`MDATA_BITS-1:0]     rdReqMdata,
  input  logic                       wrReqValid,
  input  logic [`ADDR_BITS-1:0]      wrReqAddr,
  input  logic [`LINE_BITS-1:0]      wrReqData
);

  logic                       rspValidQ;
  logic                       mmioWrQ;
  logic                       mmioRdQ;
  logic                       wrAckQ;
  logic [`MDATA_BITS-1:0]     rspMdataQ;
  logic [`LINE_BITS-1:0]      rspDataQ;
  logic [`MMIO_ADDR_BITS-1:0] mmioAddrQ;
  logic [`MMIO_TID_BITS-1:0]  mmioTidQ;
  logic [`LINE_BITS-1:0]      mmioDataQ;

  // =========================================================================
  // Rx capture and split
  // =========================================================================

  // Valids and almost-full flags start low out of reset
  always_ff @(posedge pClk)
  begin
    if (rst)
    begin
      rspValidQ <= 1'b0;
      mmioWrQ   <= 1'b0;
      mmioRdQ   <= 1'b0;
      wrAckQ    <= 1'b0;
      c0AlmFull <= 1'b0;
      c1AlmFull <= 1'b0;
    end
    else
    begin
      rspValidQ <= c0RspValid;
      mmioWrQ   <= c0MmioWrValid;
      mmioRdQ   <= c0MmioRdValid;
      wrAckQ    <= c1RspValid;
      c0AlmFull <= c0TxAlmFull;
      c1AlmFull <= c1TxAlmFull;
    end
  end

  always_ff @(posedge pClk)
  begin
    rspMdataQ <= c0RspMdata;
    rspDataQ  <= c0RspData;
    mmioAddrQ <= c0MmioAddr;
    mmioTidQ  <= c0MmioTid;
    mmioDataQ <= c0MmioData;
  end

  // The MMIO path never sees response valids, the host path never sees
  // MMIO valids, so each side can decode its own view of the shared bus
  always_comb
  begin
    mmioReq = '{wrValid: mmioWrQ, rdValid: mmioRdQ, addr: mmioAddrQ,
                tid: mmioTidQ, data: mmioDataQ};
    hostRsp = '{rdValid: rspValidQ, mdata: rspMdataQ, data: rspDataQ,
                wrAck: wrAckQ};
  end

  // =========================================================================
  // Tx output registers
  // =========================================================================

  always_ff @(posedge pClk)
  begin
    if (rst)
    begin
      c0ReqValid     <= 1'b0;
      c1ReqValid     <= 1'b0;
      c2MmioRspValid <= 1'b0;
    end
    else
    begin
      c0ReqValid     <= rdReqValid;
      c1ReqValid     <= wrReqValid;
      c2MmioRspValid <= mmioRsp.valid;
    end
  end

  always_ff @(posedge pClk)
  begin
    c0ReqAddr     <= rdReqAddr;
    c0ReqMdata    <= rdReqMdata;
    c1ReqAddr     <= wrReqAddr;
    c1ReqData     <= wrReqData;
    c2MmioRspTid  <= mmioRsp.tid;
    c2MmioRspData <= mmioRsp.data;
  end

endmodule

/* src/readReorder.sv */
// Read reorder buffer: round-robin tag allocation and in-order delivery
`include "ccipAfu_settings.svh"

module readReorder
  import ccipAfuPkg::*;
(
  input  logic                  pClk,
  input  logic                  rst,
  input  logic                  issue,
  output logic [TAG_BITS-1:0]   tag,
  output logic                  slotFree,
  input  tHostRsp               hostRsp,
  output logic                  outValid,
  output logic [`LINE_BITS-1:0] outData,
  input  logic                  outReady
);

  localparam int DEPTH = `REORDER_DEPTH;

  // Used marks a slot with a read outstanding or data not yet taken,
  // full marks a slot whose response has arrived
  logic [DEPTH-1:0]      used;
  logic [DEPTH-1:0]      full;
  logic [TAG_BITS-1:0]   issuePtr;
  logic [TAG_BITS-1:0]   headPtr;
  logic [TAG_BITS-1:0]   rspSlot;
  logic                  pop;
  logic [`LINE_BITS-1:0] slotData [DEPTH];

  // The response tag names its slot directly
  assign rspSlot = hostRsp.mdata[TAG_BITS-1:0];

  // Tags go out in ring order, so the next slot is free only once the
  // head has moved past it
  assign tag      = issuePtr;
  assign slotFree = !used[issuePtr];

  // Only the oldest request may leave, and only after its data is in
  assign outValid = full[headPtr];
  assign outData  = slotData[headPtr];
  assign pop      = outValid && outReady;

  always_ff @(posedge pClk)
  begin
    if (rst)
    begin
      used     <= '0;
      full     <= '0;
      issuePtr <= '0;
      headPtr  <= '0;
    end
    else
    begin
      if (issue)
      begin
        used[issuePtr] <= 1'b1;
        issuePtr       <= issuePtr + 1'b1;
      end
      if (hostRsp.rdValid)
        full[rspSlot] <= 1'b1;
      // The head slot is never the one being allocated or filled here
      if (pop)
      begin
        used[headPtr] <= 1'b0;
        full[headPtr] <= 1'b0;
        headPtr       <= headPtr + 1'b1;
      end
    end
  end

  // Response data lands in whatever order the host returns it
  always_ff @(posedge pClk)
  begin
    if (hostRsp.rdValid)
      slotData[rspSlot] <= hostRsp.data;
  end

endmodule

/* src/mmioCsr.sv */
// Control and status registers: feature header, AFU ID and copy job setup
`include "ccipAfu_settings.svh"

module mmioCsr
  import ccipAfuPkg::*;
(
  input  logic        pClk,
  input  logic        rst,
  input  tMmioReq     mmioReq,
  output tMmioRsp     mmioRsp,
  output tJob         job,
  output logic        start,
  input  logic        busy,
  input  logic [15:0] linesDone
);

  logic                  busyQ;
  logic                  done;
  logic [`LINE_BITS-1:0] rdData;

  // Read mux, registered into the response below
  always_comb
  begin
    case (mmioReq.addr)
      CSR_DFH:    rdData = DFH_VALUE;
      CSR_ID:     rdData = `AFU_ID;
      CSR_SRC:    rdData = `LINE_BITS'(job.src);
      CSR_DST:    rdData = `LINE_BITS'(job.dst);
      CSR_LINES:  rdData = `LINE_BITS'(job.lines);
      CSR_DSM:    rdData = `LINE_BITS'(job.dsm);
      // Busy in bit 0, done in bit 1, lines acknowledged in bits 47:32
      CSR_STATUS: rdData = {16'h0, linesDone, 30'h0, done, busy};
      default:    rdData = '0;
    endcase
  end

  always_ff @(posedge pClk)
  begin
    if (rst)
    begin
      job     <= '0;
      start   <= 1'b0;
      busyQ   <= 1'b0;
      done    <= 1'b0;
      mmioRsp <= '0;
    end
    else
    begin
      start <= 1'b0;
      busyQ <= busy;
      if (mmioReq.wrValid)
      begin
        case (mmioReq.addr)
          CSR_SRC:   job.src   <= mmioReq.data[`ADDR_BITS-1:0];
          CSR_DST:   job.dst   <= mmioReq.data[`ADDR_BITS-1:0];
          CSR_LINES: job.lines <= mmioReq.data[15:0];
          CSR_DSM:   job.dsm   <= mmioReq.data[`ADDR_BITS-1:0];
          // A kick while a job runs, or in the cycle before busy rises, is dropped
          CSR_CTRL:  start     <= mmioReq.data[0] && !busy && !start;
          default:   ;
        endcase
      end
      // Done follows the end of a job and clears when the next one starts
      if (start)
        done <= 1'b0;
      else if (busyQ && !busy)
        done <= 1'b1;
      // Each read is answered one cycle later with its own TID
      mmioRsp.valid <= mmioReq.rdValid;
      mmioRsp.tid   <= mmioReq.tid;
      mmioRsp.data  <= rdData;
    end
  end

endmodule

/* src/copyEngine.sv */
// Copy engine: issues the source line reads and the matching destination
// writes, and counts write acks to find the end of a job
`include "ccipAfu_settings.svh"

module copyEngine
  import ccipAfuPkg::*;
(
  input  logic                   pClk,
  input  logic                   rst,
  input  tJob                    job,
  input  logic                   start,
  input  logic                   c0AlmFull,
  input  tHostRsp                hostRsp,
  output logic                   issue,
  input  logic [TAG_BITS-1:0]    tag,
  input  logic                   slotFree,
  output logic                   rdValid,
  output logic [`ADDR_BITS-1:0]  rdAddr,
  output logic [`MDATA_BITS-1:0] rdMdata,
  input  logic                   inValid,
  input  logic [`LINE_BITS-1:0]  inData,
  output logic                   inReady,
  writeReqIf.requester           wr,
  output logic                   busy,
  output logic [15:0]            linesDone
);

  // Job copy taken at start, so CSR writes during a job change nothing
  logic [`ADDR_BITS-1:0] srcQ;
  logic [`ADDR_BITS-1:0] dstQ;
  logic [15:0]           linesQ;
  logic [15:0]           rdCount;
  logic [15:0]           wrCount;
  logic                  kick;

  assign kick = start && !busy;

  // =========================================================================
  // Read side
  // =========================================================================

  // One read per cycle while lines remain, a slot is free and c0 has room
  assign issue   = busy && (rdCount != linesQ) && slotFree && !c0AlmFull;
  assign rdValid = issue;
  assign rdAddr  = srcQ + `ADDR_BITS'(rdCount);
  assign rdMdata = `MDATA_BITS'(tag);

  // =========================================================================
  // Write side
  // =========================================================================

  // The head line itself is the held write request, taken on grant
  assign wr.valid = busy && inValid;
  assign wr.addr  = dstQ + `ADDR_BITS'(wrCount);
  assign wr.data  = inData;
  assign inReady  = wr.grant;

  always_ff @(posedge pClk)
  begin
    if (rst)
    begin
      busy      <= 1'b0;
      rdCount   <= '0;
      wrCount   <= '0;
      linesDone <= '0;
    end
    else if (kick)
    begin
      busy      <= 1'b1;
      rdCount   <= '0;
      wrCount   <= '0;
      linesDone <= '0;
    end
    else if (busy)
    begin
      if (issue)
        rdCount <= rdCount + 1'b1;
      if (inValid && inReady)
        wrCount <= wrCount + 1'b1;
      // Acks outside a job belong to the status record
      if (hostRsp.wrAck)
        linesDone <= linesDone + 1'b1;
      if (linesDone == linesQ)
        busy <= 1'b0;
    end
  end

  always_ff @(posedge pClk)
  begin
    if (kick)
    begin
      srcQ   <= job.src;
      dstQ   <= job.dst;
      linesQ <= job.lines;
    end
  end

endmodule

/* src/statusWriter.sv */
// Completion record writer, triggered by the end of a copy job
`include "ccipAfu_settings.svh"

module statusWriter
  import ccipAfuPkg::*;
(
  input  logic         pClk,
  input  logic         rst,
  input  tJob          job,
  input  logic         busy,
  input  logic [15:0]  linesDone,
  writeReqIf.requester wr
);

  logic                  busyQ;
  logic                  pending;
  logic                  jobEnd;
  logic [`ADDR_BITS-1:0] addrQ;
  logic [`LINE_BITS-1:0] recordQ;

  assign jobEnd   = busyQ && !busy;
  assign wr.valid = pending;
  assign wr.addr  = addrQ;
  assign wr.data  = recordQ;

  always_ff @(posedge pClk)
  begin
    if (rst)
    begin
      busyQ   <= 1'b0;
      pending <= 1'b0;
    end
    else
    begin
      busyQ <= busy;
      if (jobEnd)
        pending <= 1'b1;
      else if (wr.grant)
        pending <= 1'b0;
    end
  end

  // Record: completion flag in bit 63, line count in bits 31:0
  always_ff @(posedge pClk)
  begin
    if (jobEnd)
    begin
      addrQ   <= job.dsm;
      recordQ <= {1'b1, 31'h0, 16'h0, linesDone};
    end
  end

endmodule

/* src/txWriteArb.sv */
// Round-robin arbiter of two write requesters onto the c1 channel
`include "ccipAfu_settings.svh"

module txWriteArb
(
  input  logic                  pClk,
  input  logic                  rst,
  writeReqIf.arbiter            reqA,
  writeReqIf.arbiter            reqB,
  input  logic                  c1AlmFull,
  output logic                  c1Valid,
  output logic [`ADDR_BITS-1:0] c1Addr,
  output logic [`LINE_BITS-1:0] c1Data
);

  // Set when B wins the next tie
  logic preferB;
  logic grantA;
  logic grantB;

  // Nothing is granted while the host channel is almost full
  assign grantA = !c1AlmFull && reqA.valid && (!preferB || !reqB.valid);
  assign grantB = !c1AlmFull && reqB.valid && (preferB || !reqA.valid);

  assign reqA.grant = grantA;
  assign reqB.grant = grantB;

  assign c1Valid = grantA || grantB;
  assign c1Addr  = grantB ? reqB.addr : reqA.addr;
  assign c1Data  = grantB ? reqB.data : reqA.data;

  // The winner drops to lowest priority after each grant
  always_ff @(posedge pClk)
  begin
    if (rst)
      preferB <= 1'b0;
    else if (grantA)
      preferB <= 1'b1;
    else if (grantB)
      preferB <= 1'b0;
  end

endmodule

/* src/ccipStdAfu.sv */
// Accelerator shell top: boundary registers, CSRs, reorder buffer,
// copy engine, status writer and the c1 write arbiter
`include "ccipAfu_settings.svh"

module ccipStdAfu
  import ccipAfuPkg::*;
(
  input  logic                       pClk,
  input  logic                       rst,
  input  logic                       c0RspValid,
  input  logic [`MDATA_BITS-1:0]     c0RspMdata,
  input  logic [`LINE_BITS-1:0]      c0RspData,
  input  logic                       c0MmioWrValid,
  input  logic                       c0MmioRdValid,
  input  logic [`MMIO_ADDR_BITS-1:0] c0MmioAddr,
  input  logic [`MMIO_TID_BITS-1:0]  c0MmioTid,
  input  logic [`LINE_BITS-1:0]      c0MmioData,
  input  logic                       c1RspValid,
  input  logic                       c0TxAlmFull,
  input  logic                       c1TxAlmFull,
  output logic                       c0ReqValid,
  output logic [`ADDR_BITS-1:0]      c0ReqAddr,
  output logic [`MDATA_BITS-1:0]     c0ReqMdata,
  output logic                       c1ReqValid,
  output logic [`ADDR_BITS-1:0]      c1ReqAddr,
  output logic [`LINE_BITS-1:0]      c1ReqData,
  output logic                       c2MmioRspValid,
  output logic [`MMIO_TID_BITS-1:0]  c2MmioRspTid,
  output logic [`LINE_BITS-1:0]      c2MmioRspData
);

  tMmioReq               mmioReq;
  tMmioRsp               mmioRsp;
  tHostRsp               hostRsp;
  tJob                   job;
  logic                  c0AlmFull;
  logic                  c1AlmFull;
  logic                  rdReqValid;
  logic [`ADDR_BITS-1:0] rdReqAddr;
  logic [`MDATA_BITS-1:0] rdReqMdata;
  logic                  wrReqValid;
  logic [`ADDR_BITS-1:0] wrReqAddr;
  logic [`LINE_BITS-1:0] wrReqData;
  logic                  start;
  logic                  busy;
  logic [15:0]           linesDone;
  logic                  issue;
  logic                  slotFree;
  logic [TAG_BITS-1:0]   tag;
  logic                  lineValid;
  logic                  lineReady;
  logic [`LINE_BITS-1:0] lineData;

  // =========================================================================
  // Boundary and control
  // =========================================================================

  // Port names of the boundary block match the wires here one for one
  hostRxSplit uRxSplit (.*);

  mmioCsr uCsr (
    .pClk(pClk), .rst(rst), .mmioReq(mmioReq), .mmioRsp(mmioRsp), .job(job),
    .start(start), .busy(busy), .linesDone(linesDone)
  );

  // =========================================================================
  // Data path
  // =========================================================================

  // Copy writes and the status record share c1 through the arbiter
  writeReqIf copyWr ();
  writeReqIf statusWr ();

  readReorder uReorder (
    .pClk(pClk), .rst(rst), .issue(issue), .tag(tag), .slotFree(slotFree),
    .hostRsp(hostRsp), .outValid(lineValid), .outData(lineData),
    .outReady(lineReady)
  );

  copyEngine uCopy (
    .pClk(pClk), .rst(rst), .job(job), .start(start), .c0AlmFull(c0AlmFull),
    .hostRsp(hostRsp), .issue(issue), .tag(tag), .slotFree(slotFree),
    .rdValid(rdReqValid), .rdAddr(rdReqAddr), .rdMdata(rdReqMdata),
    .inValid(lineValid), .inData(lineData), .inReady(lineReady),
    .wr(copyWr), .busy(busy), .linesDone(linesDone)
  );

  statusWriter uStatus (
    .pClk(pClk), .rst(rst), .job(job), .busy(busy), .linesDone(linesDone),
    .wr(statusWr)
  );

  txWriteArb uWrArb (
    .pClk(pClk), .rst(rst), .reqA(copyWr), .reqB(statusWr),
    .c1AlmFull(c1AlmFull), .c1Valid(wrReqValid), .c1Addr(wrReqAddr),
    .c1Data(wrReqData)
  );

endmodule

/* test/hostMemModel.sv */
// Host memory model with a line store, out-of-order read returns and write acks
// Random almost-full on both request channels with an absorb check
`include "ccipAfu_settings.svh"

module hostMemModel
(
  input  logic                   pClk,
  input  logic                   rst,
  input  logic                   almFullOn,
  input  logic [`ADDR_BITS-1:0]  statusAddr,
  input  logic                   c0ReqValid,
  input  logic [`ADDR_BITS-1:0]  c0ReqAddr,
  input  logic [`MDATA_BITS-1:0] c0ReqMdata,
  input  logic                   c1ReqValid,
  input  logic [`ADDR_BITS-1:0]  c1ReqAddr,
  input  logic [`LINE_BITS-1:0]  c1ReqData,
  output logic                   c0RspValid,
  output logic [`MDATA_BITS-1:0] c0RspMdata,
  output logic [`LINE_BITS-1:0]  c0RspData,
  output logic                   c1RspValid,
  output logic                   c0TxAlmFull,
  output logic                   c1TxAlmFull,
  output int                     statusWrites,
  output logic [`LINE_BITS-1:0]  statusRecord,
  output logic                   c0Overrun,
  output logic                   c1Overrun
);
  timeunit 1ns;
  timeprecision 1ps;

  // Requests the host still takes after almost-full rises
  localparam int ABSORB = 4;

  logic [`LINE_BITS-1:0]  mem [logic [`ADDR_BITS-1:0]];
  logic [`MDATA_BITS-1:0] pendMdata [$];
  logic [`LINE_BITS-1:0]  pendData [$];
  int                     pendDue [$];
  int                     cycle;
  int                     pick;
  int                     c0SinceFull;
  int                     c1SinceFull;
  int                     seed = 32'h37b3;

  // Lines never written hold a value built from the whole line address
  function automatic logic [`LINE_BITS-1:0] fillPattern(input logic [`ADDR_BITS-1:0] addr);
    fillPattern = {addr ^ 32'h6b1d_3e59, addr * 32'h9e37_79b9};
  endfunction

  always @(posedge pClk)
  begin
    if (rst)
    begin
      c0RspValid   <= 1'b0;
      c0RspMdata   <= '0;
      c0RspData    <= '0;
      c1RspValid   <= 1'b0;
      c0TxAlmFull  <= 1'b0;
      c1TxAlmFull  <= 1'b0;
      statusWrites <= 0;
      c0Overrun    <= 1'b0;
      c1Overrun    <= 1'b0;
      cycle        = 0;
      c0SinceFull  = 0;
      c1SinceFull  = 0;
      pendMdata.delete();
      pendData.delete();
      pendDue.delete();
    end
    else
    begin
      cycle = cycle + 1;
      // Each read waits 1 to 20 cycles, so the returns come out of order
      if (c0ReqValid)
      begin
        pendMdata.push_back(c0ReqMdata);
        pendData.push_back(mem.exists(c0ReqAddr) ? mem[c0ReqAddr] : fillPattern(c0ReqAddr));
        pendDue.push_back(cycle + 1 + {$random(seed)} % 20);
      end
      // Writes land at once and are acked on the next cycle
      if (c1ReqValid)
      begin
        mem[c1ReqAddr] = c1ReqData;
        if (c1ReqAddr == statusAddr)
        begin
          statusRecord <= c1ReqData;
          statusWrites <= statusWrites + 1;
        end
      end
      c1RspValid <= c1ReqValid;

      // Count requests seen while each almost-full flag stays high
      if (!c0TxAlmFull)
        c0SinceFull = 0;
      else if (c0ReqValid)
        c0SinceFull = c0SinceFull + 1;
      if (!c1TxAlmFull)
        c1SinceFull = 0;
      else if (c1ReqValid)
        c1SinceFull = c1SinceFull + 1;
      if (c0SinceFull > ABSORB)
        c0Overrun <= 1'b1;
      if (c1SinceFull > ABSORB)
        c1Overrun <= 1'b1;

      // The first read that is due goes out as this cycle's only response
      pick = -1;
      foreach (pendDue[i])
      begin
        if (pick < 0 && pendDue[i] <= cycle)
          pick = i;
      end
      if (pick >= 0)
      begin
        c0RspValid <= 1'b1;
        c0RspMdata <= pendMdata[pick];
        c0RspData  <= pendData[pick];
        pendMdata.delete(pick);
        pendData.delete(pick);
        pendDue.delete(pick);
      end
      else
        c0RspValid <= 1'b0;

      // Almost-full toggles at random, giving runs of a few cycles
      if (!almFullOn)
      begin
        c0TxAlmFull <= 1'b0;
        c1TxAlmFull <= 1'b0;
      end
      else
      begin
        if (($random(seed) & 3) == 0)
          c0TxAlmFull <= !c0TxAlmFull;
        if (($random(seed) & 3) == 0)
          c1TxAlmFull <= !c1TxAlmFull;
      end
    end
  end

endmodule

/* test/ccipStdAfuTb.sv */
// Testbench of the copy accelerator shell with clock, reset, MMIO driver,
// reference model of the copy result, compare task and watchdog
`include "ccipAfu_settings.svh"

module ccipStdAfuTb
  import ccipAfuPkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  // Lines over all copy jobs set the length of the watchdog
  localparam int TOTAL_LINES = 16 + 40 + 24;

  logic                       pClk;
  logic                       rst;
  logic                       c0RspValid;
  logic [`MDATA_BITS-1:0]     c0RspMdata;
  logic [`LINE_BITS-1:0]      c0RspData;
  logic                       c0MmioWrValid;
  logic                       c0MmioRdValid;
  logic [`MMIO_ADDR_BITS-1:0] c0MmioAddr;
  logic [`MMIO_TID_BITS-1:0]  c0MmioTid;
  logic [`LINE_BITS-1:0]      c0MmioData;
  logic                       c1RspValid;
  logic                       c0TxAlmFull;
  logic                       c1TxAlmFull;
  logic                       c0ReqValid;
  logic [`ADDR_BITS-1:0]      c0ReqAddr;
  logic [`MDATA_BITS-1:0]     c0ReqMdata;
  logic                       c1ReqValid;
  logic [`ADDR_BITS-1:0]      c1ReqAddr;
  logic [`LINE_BITS-1:0]      c1ReqData;
  logic                       c2MmioRspValid;
  logic [`MMIO_TID_BITS-1:0]  c2MmioRspTid;
  logic [`LINE_BITS-1:0]      c2MmioRspData;
  logic                       almFullOn;
  logic [`ADDR_BITS-1:0]      statusAddr;
  int                         statusWrites;
  logic [`LINE_BITS-1:0]      statusRecord;
  logic                       c0Overrun;
  logic                       c1Overrun;

  ccipStdAfu u_dut (.*);

  hostMemModel u_mem (.*);

  always #50 pClk = !pClk;

  // =========================================================================
  // Reference model
  // =========================================================================

  // Feature header of an AFU that is the last in the feature list
  localparam logic [63:0] AFU_DFH = {4'h1, 19'h0, 1'b1, 40'h0};

  // Source lines as the host memory holds them before any write
  function automatic logic [63:0] expectedDst(input logic [31:0] src, input int index);
    logic [31:0] addr;
    addr = src + index;
    expectedDst = {addr ^ 32'h6b1d_3e59, addr * 32'h9e37_79b9};
  endfunction

  // Completion flag in bit 63 and the line count in the low word
  function automatic logic [63:0] expectedRecord(input logic [15:0] lines);
    expectedRecord = (64'h1 << 63) | 64'(lines);
  endfunction

  // STATUS has busy in bit 0, done in bit 1 and the acked lines from bit 32
  function automatic logic [63:0] statusWord(input logic busy, input logic done,
                                             input logic [15:0] lines);
    statusWord = 64'(busy) | (64'(done) << 1) | (64'(lines) << 32);
  endfunction

  // =========================================================================
  // Checks and MMIO driver
  // =========================================================================

  task automatic checkValue(input string name, input logic [63:0] expected,
                            input logic [63:0] actual);
    if (actual !== expected)
    begin
      $display("MISMATCH %s expected %h actual %h", name, expected, actual);
      $display("tests failed");
      $fatal(1);
    end
  endtask

  task automatic mmioWrite(input tMmioAddr addr, input logic [63:0] data);
    @(posedge pClk);
    c0MmioWrValid <= 1'b1;
    c0MmioAddr    <= addr;
    c0MmioData    <= data;
    @(posedge pClk);
    c0MmioWrValid <= 1'b0;
  endtask

  // The response must show up exactly 3 cycles after the request cycle
  task automatic mmioRead(input tMmioAddr addr, input logic [8:0] tid,
                          input logic [63:0] expected);
    @(posedge pClk);
    c0MmioRdValid <= 1'b1;
    c0MmioAddr    <= addr;
    c0MmioTid     <= tid;
    for (int cyc = 1; cyc <= 4; cyc++)
    begin
      @(posedge pClk);
      if (cyc == 1)
        c0MmioRdValid <= 1'b0;
      checkValue("c2MmioRspValid", 64'(cyc == 4), 64'(c2MmioRspValid));
    end
    checkValue("c2MmioRspTid", 64'(tid), 64'(c2MmioRspTid));
    checkValue("c2MmioRspData", expected, c2MmioRspData);
  endtask

  // Program one job, start it and check everything it leaves behind
  task automatic runCopy(input logic [31:0] src, input logic [31:0] dst,
                         input logic [15:0] lines, input logic [31:0] dsm,
                         input logic tryRestart);
    int prevWrites;
    statusAddr <= dsm;
    mmioWrite(CSR_SRC, 64'(src));
    mmioWrite(CSR_DST, 64'(dst));
    mmioWrite(CSR_LINES, 64'(lines));
    mmioWrite(CSR_DSM, 64'(dsm));
    prevWrites = statusWrites;
    mmioWrite(CSR_CTRL, 64'h1);
    // A second kick with a new length lands while the first job runs
    if (tryRestart)
    begin
      while (!u_dut.busy)
        @(posedge pClk);
      mmioWrite(CSR_LINES, 64'h5);
      mmioWrite(CSR_CTRL, 64'h1);
    end
    // The record write to the status address marks the end of the job
    while (statusWrites == prevWrites)
      @(posedge pClk);
    checkValue("statusRecord", expectedRecord(lines), statusRecord);
    for (int i = 0; i < int'(lines); i++)
      checkValue($sformatf("mem[%h]", dst + i), expectedDst(src, i), u_mem.mem[dst + i]);
    mmioRead(CSR_STATUS, 9'h0a5, statusWord(1'b0, 1'b1, lines));
    checkValue("c0Overrun", 64'h0, 64'(c0Overrun));
    checkValue("c1Overrun", 64'h0, 64'(c1Overrun));
    if (tryRestart)
    begin
      repeat (100) @(posedge pClk);
      checkValue("statusWrites", 64'(prevWrites + 1), 64'(statusWrites));
    end
  endtask

  // =========================================================================
  // Test sequence
  // =========================================================================

  initial
  begin
    pClk          = 1'b0;
    rst           = 1'b1;
    c0MmioWrValid = 1'b0;
    c0MmioRdValid = 1'b0;
    c0MmioAddr    = '0;
    c0MmioTid     = '0;
    c0MmioData    = '0;
    almFullOn     = 1'b0;
    statusAddr    = '0;
    repeat (10) @(posedge pClk);
    rst <= 1'b0;

    // Constant feature header and AFU ID
    mmioRead(CSR_DFH, 9'h005, AFU_DFH);
    mmioRead(CSR_ID, 9'h1a3, `AFU_ID);

    // Idle status and then job register read-back
    mmioRead(CSR_STATUS, 9'h011, statusWord(1'b0, 1'b0, 16'h0));
    mmioWrite(CSR_SRC, 64'h1234_5678);
    mmioWrite(CSR_DST, 64'h9abc_def0);
    mmioWrite(CSR_LINES, 64'h0bad);
    mmioWrite(CSR_DSM, 64'h00c0_ffee);
    mmioRead(CSR_SRC, 9'h020, 64'h1234_5678);
    mmioRead(CSR_DST, 9'h021, 64'h9abc_def0);
    mmioRead(CSR_LINES, 9'h022, 64'h0bad);
    mmioRead(CSR_DSM, 9'h023, 64'h00c0_ffee);

    // Plain copy with out-of-order read returns
    runCopy(32'h0000_1000, 32'h0000_2000, 16'd16, 32'h0000_3000, 1'b0);

    // Copy under random almost-full on both channels
    almFullOn <= 1'b1;
    runCopy(32'h0000_8000, 32'h0000_a000, 16'd40, 32'h0000_3040, 1'b0);
    almFullOn <= 1'b0;

    // Kick while busy must not restart the job
    runCopy(32'h0000_5000, 32'h0000_6000, 16'd24, 32'h0000_3080, 1'b1);

    $display("all tests passed");
    $finish;
  end

  // Upper bound on the whole run
  initial
  begin
    repeat (TOTAL_LINES * 40 + 2000) @(posedge pClk);
    $display("The run timed out before the last test finished");
    $display("tests failed");
    $fatal(1);
  end

endmodule

/* filelist.f */
+incdir+src
src/ccipAfuPkg.sv
src/writeReqIf.sv
src/hostRxSplit.sv
src/readReorder.sv
src/mmioCsr.sv
src/copyEngine.sv
src/statusWriter.sv
src/txWriteArb.sv
src/ccipStdAfu.sv
test/hostMemModel.sv
test/ccipStdAfuTb.sv
